// File: flist.f
source/hdc_pkg.sv
source/hdc_op_if.sv
source/cmd_decode.sv
source/bundle_execute.sv
source/result_stream.sv
source/hdc_bundler_top.sv
sim/hdc_bundler_checker.sv
sim/hdc_bundler_props.sv
sim/hdc_bundler_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the bundler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module hdc_bundler_tb \
    -f flist.f -o sim_hdc_bundler
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

# high error limit so assertion failures reach the final report
output=$(./obj_dir/sim_hdc_bundler +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1

// File: sim/hdc_bundler_tb.sv
`timescale 1ns/100ps

module hdc_bundler_tb;

    typedef enum logic [1:0] {V_ZERO, V_ONES, V_FIX, V_RAND} vec_kind_e;
    typedef enum logic [1:0] {E_NONE, E_ZERO, E_ONES, E_FIX} exp_kind_e;

    // one table row, issued reps times back to back
    // arg is the core mask, or the first slice index of a read row
    // rnd draws op, mask and slice per rep from the lcg
    typedef struct packed {
        hdc_pkg::hdc_op_e op;
        logic [3:0]       arg;
        logic             rnd;
        vec_kind_e        vec;
        exp_kind_e        want;
        logic [7:0]       reps;
    } row_t;

    logic                                            clk = 1'b0;
    logic                                            rst;
    logic                                            cmd_valid;
    logic [hdc_pkg::CMD_W-1:0]                       cmd_word;
    logic [hdc_pkg::NUM_CORES-1:0][hdc_pkg::DIM-1:0] core_result;
    logic                                            out_valid;
    logic [hdc_pkg::OUT_W-1:0]                       out_data;
    logic [hdc_pkg::SEL_W-1:0]                       out_sel;
    logic                                            dir_en;
    logic [hdc_pkg::OUT_W-1:0]                       dir_data;
    int                                              value_errs;
    int                                              proto_errs;
    int                                              pending;
    logic [31:0]                                     lcg_state = 32'hb1a51e53;

    row_t rows [0:28] = '{
        // fresh after reset, ties read as zero
        '{hdc_pkg::OP_READ,  4'd0,    1'b0, V_ZERO, E_ZERO, 8'd4},
        // core 0 alone comes back unchanged
        '{hdc_pkg::OP_CLEAR, 4'd0,    1'b0, V_ZERO, E_NONE, 8'd1},
        '{hdc_pkg::OP_ACCUM, 4'b0001, 1'b0, V_FIX,  E_NONE, 8'd1},
        '{hdc_pkg::OP_READ,  4'd0,    1'b0, V_ZERO, E_FIX,  8'd4},
        // nop and an empty mask change nothing
        '{hdc_pkg::OP_NOP,   4'hf,    1'b0, V_RAND, E_NONE, 8'd3},
        '{hdc_pkg::OP_ACCUM, 4'b0000, 1'b0, V_ONES, E_NONE, 8'd2},
        '{hdc_pkg::OP_READ,  4'd0,    1'b0, V_ZERO, E_FIX,  8'd4},
        // reads right behind a clear and an accumulate
        '{hdc_pkg::OP_CLEAR, 4'd0,    1'b0, V_ZERO, E_NONE, 8'd1},
        '{hdc_pkg::OP_READ,  4'd2,    1'b0, V_ZERO, E_ZERO, 8'd1},
        '{hdc_pkg::OP_ACCUM, 4'b0001, 1'b0, V_FIX,  E_NONE, 8'd1},
        '{hdc_pkg::OP_READ,  4'd2,    1'b0, V_ZERO, E_FIX,  8'd1},
        // clamp at +127, then 31 full-mask steps down leave +3
        '{hdc_pkg::OP_CLEAR, 4'd0,    1'b0, V_ZERO, E_NONE, 8'd1},
        '{hdc_pkg::OP_ACCUM, 4'hf,    1'b0, V_ONES, E_NONE, 8'd40},
        '{hdc_pkg::OP_ACCUM, 4'hf,    1'b0, V_ZERO, E_NONE, 8'd31},
        '{hdc_pkg::OP_READ,  4'd0,    1'b0, V_ZERO, E_ONES, 8'd4},
        // one more step gives -1
        '{hdc_pkg::OP_ACCUM, 4'hf,    1'b0, V_ZERO, E_NONE, 8'd1},
        '{hdc_pkg::OP_READ,  4'd1,    1'b0, V_ZERO, E_ZERO, 8'd1},
        // mirror image from -127
        '{hdc_pkg::OP_ACCUM, 4'hf,    1'b0, V_ZERO, E_NONE, 8'd40},
        '{hdc_pkg::OP_ACCUM, 4'hf,    1'b0, V_ONES, E_NONE, 8'd31},
        '{hdc_pkg::OP_READ,  4'd3,    1'b0, V_ZERO, E_ZERO, 8'd1},
        '{hdc_pkg::OP_ACCUM, 4'hf,    1'b0, V_ONES, E_NONE, 8'd1},
        '{hdc_pkg::OP_READ,  4'd0,    1'b0, V_ZERO, E_ONES, 8'd4},
        '{hdc_pkg::OP_CLEAR, 4'd0,    1'b0, V_ZERO, E_NONE, 8'd1},
        '{hdc_pkg::OP_READ,  4'd0,    1'b0, V_ZERO, E_ZERO, 8'd4},
        // random traffic, checked against the model only
        '{hdc_pkg::OP_ACCUM, 4'd0,    1'b1, V_RAND, E_NONE, 8'd120},
        '{hdc_pkg::OP_READ,  4'd0,    1'b0, V_RAND, E_NONE, 8'd4},
        '{hdc_pkg::OP_CLEAR, 4'd0,    1'b0, V_RAND, E_NONE, 8'd1},
        '{hdc_pkg::OP_ACCUM, 4'd0,    1'b1, V_RAND, E_NONE, 8'd80},
        '{hdc_pkg::OP_READ,  4'd0,    1'b0, V_RAND, E_NONE, 8'd4}
    };

    always #4 clk = ~clk;

    hdc_bundler_top UUT (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_word    (cmd_word),
        .core_result (core_result),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_sel     (out_sel)
    );

    hdc_bundler_checker u_check (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_word    (cmd_word),
        .core_result (core_result),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_sel     (out_sel),
        .dir_en      (dir_en),
        .dir_data    (dir_data),
        .value_errs  (value_errs),
        .proto_errs  (proto_errs),
        .pending     (pending)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // core 0 gets the pattern, the others its inverse
    function automatic logic [hdc_pkg::DIM-1:0] fixed_vec(input int core);
        return (core == 0) ? 64'h0123_4567_89ab_cdef : ~64'h0123_4567_89ab_cdef;
    endfunction

    // drive one command at the falling edge, hold it for one cycle
    task automatic drive_cmd(input hdc_pkg::hdc_op_e op, input logic [3:0] arg,
                             input vec_kind_e vec, input exp_kind_e want);
        hdc_pkg::hdc_cmd_u       word;
        logic [1:0]              sel;
        logic [hdc_pkg::DIM-1:0] fix;
        sel = arg[1:0];
        fix = fixed_vec(0);
        word = '0;
        if (op == hdc_pkg::OP_READ) begin
            word.rd.op = op;
            word.rd.word_sel = sel;
        end else begin
            word.accum.op = op;
            word.accum.core_mask = arg;
        end
        for (int c = 0; c < hdc_pkg::NUM_CORES; c++) begin
            case (vec)
                V_ZERO:  core_result[c] = '0;
                V_ONES:  core_result[c] = '1;
                V_FIX:   core_result[c] = fixed_vec(c);
                default: core_result[c] = {next_rand(), next_rand()};
            endcase
        end
        cmd_valid = 1'b1;
        cmd_word = word;
        dir_en = (op == hdc_pkg::OP_READ) && (want != E_NONE);
        case (want)
            E_ONES:  dir_data = '1;
            E_FIX:   dir_data = fix[sel*16 +: 16];
            default: dir_data = '0;
        endcase
        @(negedge clk);
    endtask

    task automatic idle_cycle();
        cmd_valid = 1'b0;
        dir_en = 1'b0;
        @(negedge clk);
    endtask

    initial begin
        row_t        r;
        logic [31:0] rv;
        logic [3:0]  arg;
        int          wait_cyc;
        int          total;
        bit          timed_out;
        timed_out = 1'b0;
        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd_word = '0;
        core_result = '0;
        dir_en = 1'b0;
        dir_data = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        foreach (rows[i]) begin
            r = rows[i];
            for (int k = 0; k < int'(r.reps); k++) begin
                if (r.rnd) begin
                    // upper lcg bits, the low ones repeat quickly
                    rv = next_rand();
                    if (rv[23:22] == 2'b00) begin
                        idle_cycle();
                    end
                    if (rv[31:30] == 2'b00) begin
                        drive_cmd(hdc_pkg::OP_READ, {2'b00, rv[29:28]}, V_RAND, E_NONE);
                    end else begin
                        drive_cmd(hdc_pkg::OP_ACCUM, rv[27:24], V_RAND, E_NONE);
                    end
                end else begin
                    arg = (r.op == hdc_pkg::OP_READ) ? r.arg + 4'(k) : r.arg;
                    drive_cmd(r.op, arg, r.vec, r.want);
                end
            end
        end
        idle_cycle();

        for (wait_cyc = 0; wait_cyc < 20 && pending != 0; wait_cyc++) begin
            @(negedge clk);
        end
        if (pending != 0) begin
            timed_out = 1'b1;
            $display("timeout: %0d expected read outputs never arrived", pending);
        end
        // catch any stray out_valid
        repeat (4) @(negedge clk);

        total = value_errs + proto_errs + UUT.u_props.assert_fails;
        $display("error counts: %0d value, %0d protocol, %0d assertion",
                 value_errs, proto_errs, UUT.u_props.assert_fails);
        if (total == 0 && !timed_out) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sim/hdc_bundler_props.sv
`timescale 1ns/100ps

module hdc_bundler_props (
    input logic                      clk,
    input logic                      rst,
    input logic                      cmd_valid,
    input logic [hdc_pkg::CMD_W-1:0] cmd_word,
    input logic                      op_valid,
    input logic                      do_clear,
    input logic                      do_accum,
    input logic                      do_read,
    input logic                      rd_valid,
    input logic                      out_valid
);

    hdc_pkg::hdc_cmd_u cmd_u;
    logic              read_cmd;
    int                assert_fails = 0;

    assign cmd_u = cmd_word;
    assign read_cmd = cmd_valid && (cmd_u.rd.op == hdc_pkg::OP_READ);

    // three pipeline stages from command strobe to out_valid
    read_to_out: assert property (@(posedge clk) disable iff (rst)
        $past(read_cmd, 3) |-> out_valid)
        else begin
            assert_fails++;
            $error("read command not followed by out_valid three cycles later");
        end

    out_from_read: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $past(read_cmd, 3))
        else begin
            assert_fails++;
            $error("out_valid without a read command three cycles earlier");
        end

    quiet_in_reset: assert property (@(posedge clk)
        $past(rst) |-> !op_valid && !rd_valid && !out_valid)
        else begin
            assert_fails++;
            $error("control strobe high while in reset");
        end

    one_op_kind: assert property (@(posedge clk) disable iff (rst)
        op_valid |-> $onehot({do_clear, do_accum, do_read}))
        else begin
            assert_fails++;
            $error("decoded operation flags not one-hot");
        end

endmodule

bind hdc_bundler_top hdc_bundler_props u_props (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_word  (cmd_word),
    .op_valid  (op_bus.op_valid),
    .do_clear  (op_bus.do_clear),
    .do_accum  (op_bus.do_accum),
    .do_read   (op_bus.do_read),
    .rd_valid  (rd_valid),
    .out_valid (out_valid)
);

// File: sim/hdc_bundler_checker.sv
`timescale 1ns/100ps

module hdc_bundler_checker (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            cmd_valid,
    input  logic [hdc_pkg::CMD_W-1:0]                       cmd_word,
    input  logic [hdc_pkg::NUM_CORES-1:0][hdc_pkg::DIM-1:0] core_result,
    input  logic                                            out_valid,
    input  logic [hdc_pkg::OUT_W-1:0]                       out_data,
    input  logic [hdc_pkg::SEL_W-1:0]                       out_sel,
    input  logic                                            dir_en,
    input  logic [hdc_pkg::OUT_W-1:0]                       dir_data,
    output int                                              value_errs,
    output int                                              proto_errs,
    output int                                              pending
);

    // one outstanding read
    typedef struct packed {
        logic [hdc_pkg::OUT_W-1:0] data;
        logic [hdc_pkg::SEL_W-1:0] sel;
        logic                      den;
        logic [hdc_pkg::OUT_W-1:0] dval;
        int                        cyc;
    } read_t;

    hdc_pkg::hdc_cmd_u cmd_u;
    int                model_cnt [hdc_pkg::DIM];
    read_t             read_q [$];
    int                cyc;

    assign cmd_u = cmd_word;

    // votes of the masked cores in one step, then clamp
    task automatic model_accum(input logic [hdc_pkg::NUM_CORES-1:0] mask);
        int sum;
        for (int d = 0; d < hdc_pkg::DIM; d++) begin
            sum = model_cnt[d];
            for (int c = 0; c < hdc_pkg::NUM_CORES; c++) begin
                if (mask[c]) begin
                    sum += core_result[c][d] ? 1 : -1;
                end
            end
            if (sum > 127) begin
                sum = 127;
            end else if (sum < -127) begin
                sum = -127;
            end
            model_cnt[d] = sum;
        end
    endtask

    function automatic logic [hdc_pkg::OUT_W-1:0] model_slice(input logic [1:0] sel);
        logic [hdc_pkg::OUT_W-1:0] s;
        for (int b = 0; b < hdc_pkg::OUT_W; b++) begin
            s[b] = model_cnt[int'(sel) * hdc_pkg::OUT_W + b] > 0;
        end
        return s;
    endfunction

    task automatic check_output();
        read_t rd;
        if (read_q.size() == 0) begin
            proto_errs++;
            $display("out_valid at %0t with no read outstanding", $time);
        end else begin
            rd = read_q.pop_front();
            if (cyc - rd.cyc != 3) begin
                proto_errs++;
                $display("read output at %0t came %0d cycles after its command, not 3",
                         $time, cyc - rd.cyc);
            end
            if (out_sel !== rd.sel) begin
                value_errs++;
                $display("mismatch at %0t: out_sel %0d, expected %0d", $time, out_sel, rd.sel);
            end
            if (out_data !== rd.data) begin
                value_errs++;
                $display("mismatch at %0t: slice %0d is %h, model gives %h",
                         $time, rd.sel, out_data, rd.data);
            end
            if (rd.den && out_data !== rd.dval) begin
                value_errs++;
                $display("mismatch at %0t: slice %0d is %h, directed value %h",
                         $time, rd.sel, out_data, rd.dval);
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            foreach (model_cnt[d]) begin
                model_cnt[d] = 0;
            end
            read_q.delete();
            cyc = 0;
            value_errs = 0;
            proto_errs = 0;
        end else begin
            cyc++;
            if (out_valid) begin
                check_output();
            end
            if (cmd_valid) begin
                case (cmd_u.accum.op)
                    hdc_pkg::OP_CLEAR: begin
                        foreach (model_cnt[d]) begin
                            model_cnt[d] = 0;
                        end
                    end
                    hdc_pkg::OP_ACCUM: model_accum(cmd_u.accum.core_mask);
                    hdc_pkg::OP_READ: begin
                        read_q.push_back('{model_slice(cmd_u.rd.word_sel), cmd_u.rd.word_sel,
                                           dir_en, dir_data, cyc});
                    end
                    default: ;
                endcase
            end
        end
        pending = read_q.size();
    end

endmodule

// File: source/hdc_bundler_top.sv
`timescale 1ns/100ps
`default_nettype none

module hdc_bundler_top (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            cmd_valid,
    input  logic [hdc_pkg::CMD_W-1:0]                       cmd_word,
    input  logic [hdc_pkg::NUM_CORES-1:0][hdc_pkg::DIM-1:0] core_result,
    output logic                                            out_valid,
    output logic [hdc_pkg::OUT_W-1:0]                       out_data,
    output logic [hdc_pkg::SEL_W-1:0]                       out_sel
);

    // decoded operation bus
    hdc_op_if op_bus ();

    // execute to output stage
    logic                      rd_valid;
    logic [hdc_pkg::SEL_W-1:0] rd_sel;
    logic [hdc_pkg::DIM-1:0]   sign_vec;

    // stage 1, command register and field split
    cmd_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_word    (cmd_word),
        .core_result (core_result),
        .op          (op_bus.src)
    );

    // stage 2, vote counters
    bundle_execute u_execute (
        .clk      (clk),
        .rst      (rst),
        .op       (op_bus.dst),
        .rd_valid (rd_valid),
        .rd_sel   (rd_sel),
        .sign_vec (sign_vec)
    );

    // stage 3, slice output register
    result_stream u_result (
        .clk       (clk),
        .rst       (rst),
        .rd_valid  (rd_valid),
        .rd_sel    (rd_sel),
        .sign_vec  (sign_vec),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_sel   (out_sel)
    );

endmodule

`default_nettype wire

// File: source/result_stream.sv
`timescale 1ns/100ps
`default_nettype none

module result_stream (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rd_valid,
    input  logic [hdc_pkg::SEL_W-1:0] rd_sel,
    input  logic [hdc_pkg::DIM-1:0]   sign_vec,
    output logic                      out_valid,
    output logic [hdc_pkg::OUT_W-1:0] out_data,
    output logic [hdc_pkg::SEL_W-1:0] out_sel
);

    // sign vector viewed as slices, dimension 0 lands in bit 0 of slice 0
    logic [hdc_pkg::NUM_WORDS-1:0][hdc_pkg::OUT_W-1:0] slices;

    assign slices = sign_vec;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= rd_valid;
        end
    end

    // slice mux into the output register
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            out_data <= slices[rd_sel];
            out_sel  <= rd_sel;
        end
    end

endmodule

`default_nettype wire

// File: source/bundle_execute.sv
`timescale 1ns/100ps
`default_nettype none

module bundle_execute (
    input  logic                      clk,
    input  logic                      rst,
    hdc_op_if.dst                     op,
    output logic                      rd_valid,
    output logic [hdc_pkg::SEL_W-1:0] rd_sel,
    output logic [hdc_pkg::DIM-1:0]   sign_vec
);

    localparam int CW = hdc_pkg::CNT_W;

    // one vote counter per dimension
    logic signed [CW-1:0] cnt [hdc_pkg::DIM];

    // one guard bit so the raw sum cannot wrap before clamping
    logic signed [CW:0]   acc_sum  [hdc_pkg::DIM];
    logic signed [CW-1:0] cnt_next [hdc_pkg::DIM];

    logic [hdc_pkg::DIM-1:0] sign_now;

    // add all masked votes in one step, then saturate
    always_comb begin
        for (int d = 0; d < hdc_pkg::DIM; d++) begin
            acc_sum[d] = {cnt[d][CW-1], cnt[d]};
            for (int c = 0; c < hdc_pkg::NUM_CORES; c++) begin
                if (op.core_mask[c]) begin
                    // set bit votes +1, clear bit votes -1
                    if (op.core_vec[c][d]) begin
                        acc_sum[d] = acc_sum[d] + 1;
                    end else begin
                        acc_sum[d] = acc_sum[d] - 1;
                    end
                end
            end
            if (acc_sum[d] > hdc_pkg::CNT_MAX) begin
                cnt_next[d] = CW'(hdc_pkg::CNT_MAX);
            end else if (acc_sum[d] < -hdc_pkg::CNT_MAX) begin
                cnt_next[d] = CW'(-hdc_pkg::CNT_MAX);
            end else begin
                cnt_next[d] = acc_sum[d][CW-1:0];
            end
        end
    end

    // sign bit set only for strictly positive counts, ties give 0
    always_comb begin
        for (int d = 0; d < hdc_pkg::DIM; d++) begin
            sign_now[d] = !cnt[d][CW-1] && (cnt[d] != '0);
        end
    end

    always_ff @(posedge clk) begin
        for (int d = 0; d < hdc_pkg::DIM; d++) begin
            if (rst || (op.op_valid && op.do_clear)) begin
                cnt[d] <= '0;
            end else if (op.op_valid && op.do_accum) begin
                cnt[d] <= cnt_next[d];
            end
        end
    end

    // read strobe to the output stage
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= op.op_valid && op.do_read;
        end
    end

    // snapshot reflects every earlier command
    always_ff @(posedge clk) begin
        if (op.op_valid && op.do_read) begin
            rd_sel   <= op.word_sel;
            sign_vec <= sign_now;
        end
    end

endmodule

`default_nettype wire

// File: source/cmd_decode.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_decode (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            cmd_valid,
    input  hdc_pkg::hdc_cmd_u                               cmd_word,
    input  logic [hdc_pkg::NUM_CORES-1:0][hdc_pkg::DIM-1:0] core_result,
    hdc_op_if.src                                           op
);

    hdc_pkg::hdc_op_e opcode;
    logic             is_op;

    // opcode field is common to both views
    assign opcode = cmd_word.accum.op;

    // nop never leaves this stage
    assign is_op = cmd_valid && (opcode != hdc_pkg::OP_NOP);

    // control strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            op.op_valid <= 1'b0;
            op.do_clear <= 1'b0;
            op.do_accum <= 1'b0;
            op.do_read  <= 1'b0;
        end else begin
            op.op_valid <= is_op;
            op.do_clear <= is_op && (opcode == hdc_pkg::OP_CLEAR);
            op.do_accum <= is_op && (opcode == hdc_pkg::OP_ACCUM);
            op.do_read  <= is_op && (opcode == hdc_pkg::OP_READ);
        end
    end

    // operand fields, taken from the view that matches the opcode
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            if (opcode == hdc_pkg::OP_ACCUM) begin
                op.core_mask <= cmd_word.accum.core_mask;
            end else begin
                op.core_mask <= '0;
            end
            if (opcode == hdc_pkg::OP_READ) begin
                op.word_sel <= cmd_word.rd.word_sel;
            end else begin
                op.word_sel <= '0;
            end
            // core vectors sampled together with the strobe
            op.core_vec <= core_result;
        end
    end

endmodule

`default_nettype wire

// File: source/hdc_op_if.sv
`timescale 1ns/100ps
`default_nettype none

// decoded operation, decode stage to execute stage
interface hdc_op_if;

    // one-cycle strobe, exactly one of the do_* flags set with it
    logic op_valid;
    logic do_clear;
    logic do_accum;
    logic do_read;

    // operands
    logic [hdc_pkg::NUM_CORES-1:0] core_mask;
    logic [hdc_pkg::SEL_W-1:0]     word_sel;

    // core hypervectors captured with the command
    logic [hdc_pkg::NUM_CORES-1:0][hdc_pkg::DIM-1:0] core_vec;

    modport src (
        output op_valid,
        output do_clear,
        output do_accum,
        output do_read,
        output core_mask,
        output word_sel,
        output core_vec
    );

    modport dst (
        input op_valid,
        input do_clear,
        input do_accum,
        input do_read,
        input core_mask,
        input word_sel,
        input core_vec
    );

endinterface

`default_nettype wire

// File: source/hdc_pkg.sv
package hdc_pkg;

    // hypervector and core sizes
    localparam int DIM = 64;
    localparam int NUM_CORES = 4;

    // signed vote counter, symmetric saturation
    localparam int CNT_W = 8;
    localparam int CNT_MAX = 127;

    // output streaming
    localparam int OUT_W = 16;
    localparam int NUM_WORDS = DIM / OUT_W;
    localparam int SEL_W = 2;

    // command word width
    localparam int CMD_W = 16;

    typedef enum logic [1:0] {
        OP_NOP   = 2'b00,
        OP_CLEAR = 2'b01,
        OP_ACCUM = 2'b10,
        OP_READ  = 2'b11
    } hdc_op_e;

    // one command word, two views
    // op sits in bits 15:14 in both
    typedef union packed {
        // accumulate: core select mask in the low bits
        struct packed {
            hdc_op_e                    op;
            logic [CMD_W-3-NUM_CORES:0] rsvd;
            logic [NUM_CORES-1:0]       core_mask;
        } accum;
        // read: slice index in the low bits
        struct packed {
            hdc_op_e                op;
            logic [CMD_W-3-SEL_W:0] rsvd;
            logic [SEL_W-1:0]       word_sel;
        } rd;
    } hdc_cmd_u;

endpackage
